// ==== rtl/fp_pkg.sv ====
package fp_pkg;

  localparam int XLEN = 32;
  localparam int REG_AW = 5;
  localparam int FFLAGS_W = 5;
  localparam int FRM_W = 3;
  localparam int FMT_W = 2;
  localparam int CSR_AW = 12;
  localparam int FP_OP_W = 19;
  localparam int LSU_OP_W = 2;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [FFLAGS_W-1:0] fflags_t; // NV, DZ, OF, UF, NX.
  typedef logic [FRM_W-1:0] frm_t;
  typedef logic [FMT_W-1:0] fmt_t;
  typedef logic [CSR_AW-1:0] csr_addr_t;
  typedef logic [FP_OP_W-1:0] fp_op_t;
  typedef logic [LSU_OP_W-1:0] lsu_op_t;

  // One-hot operation bits.
  localparam int OP_FADD = 0;
  localparam int OP_FSUB = 1;
  localparam int OP_FMUL = 2;
  localparam int OP_FDIV = 3;
  localparam int OP_FSQRT = 4;
  localparam int OP_FSGNJ = 5;
  localparam int OP_FMAX = 6;
  localparam int OP_FCMP = 7;
  localparam int OP_FMV_F2I = 8;
  localparam int OP_FCLASS = 9;
  localparam int OP_FMV_I2F = 10;
  localparam int OP_FCVT_F2I = 11;
  localparam int OP_FCVT_I2F = 12;
  localparam int OP_FMADD = 13;
  localparam int OP_FMSUB = 14;
  localparam int OP_FNMSUB = 15;
  localparam int OP_FNMADD = 16;
  localparam int OP_CVT_LO = 17; // Two bits of fcvt sub-op start here.

  localparam int LSU_LW = 0;
  localparam int LSU_SW = 1;

  localparam logic [6:0] OPCODE_FLOAD = 7'b0000111;
  localparam logic [6:0] OPCODE_FSTORE = 7'b0100111;
  localparam logic [6:0] OPCODE_FP = 7'b1010011;
  localparam logic [6:0] OPCODE_FMADD = 7'b1000011;
  localparam logic [6:0] OPCODE_FMSUB = 7'b1000111;
  localparam logic [6:0] OPCODE_FNMSUB = 7'b1001011;
  localparam logic [6:0] OPCODE_FNMADD = 7'b1001111;

  // Upper five bits of funct7 in the OP-FP group.
  localparam logic [4:0] FUNCT_FADD = 5'b00000;
  localparam logic [4:0] FUNCT_FSUB = 5'b00001;
  localparam logic [4:0] FUNCT_FMUL = 5'b00010;
  localparam logic [4:0] FUNCT_FDIV = 5'b00011;
  localparam logic [4:0] FUNCT_FSGNJ = 5'b00100;
  localparam logic [4:0] FUNCT_FMINMAX = 5'b00101;
  localparam logic [4:0] FUNCT_FSQRT = 5'b01011;
  localparam logic [4:0] FUNCT_FCMP = 5'b10100;
  localparam logic [4:0] FUNCT_FMV_F2I = 5'b11100;
  localparam logic [4:0] FUNCT_FMV_I2F = 5'b11110;
  localparam logic [4:0] FUNCT_FCVT_F2I = 5'b11000;
  localparam logic [4:0] FUNCT_FCVT_I2F = 5'b11010;

  localparam logic [2:0] FUNCT_LW = 3'b010;
  localparam logic [2:0] FUNCT_SW = 3'b010;

  localparam csr_addr_t CSR_FFLAGS = 12'h001;
  localparam csr_addr_t CSR_FRM = 12'h002;
  localparam csr_addr_t CSR_FCSR = 12'h003;

  localparam frm_t RM_DYN = 3'd7;

endpackage

// ==== rtl/fp_decode.sv ====
`timescale 1ns/1ps

module fp_decode (
  input  logic              clock,
  input  logic              reset,
  input  fp_pkg::word_t     instr_i,
  input  logic              instr_valid_i,
  input  fp_pkg::frm_t      frm_i,
  output logic              valid_o,
  output logic              wren_o,
  output logic              rden1_o,
  output logic              fwren_o,
  output logic              frden1_o,
  output logic              frden2_o,
  output logic              frden3_o,
  output logic              fload_o,
  output logic              fstore_o,
  output logic              fpu_o,
  output logic              fpuc_o,
  output logic              fpuf_o,
  output fp_pkg::fp_op_t    fp_op_o,
  output fp_pkg::lsu_op_t   lsu_op_o,
  output fp_pkg::word_t     imm_o,
  output fp_pkg::fmt_t      fmt_o,
  output fp_pkg::frm_t      rm_o,
  output fp_pkg::reg_addr_t raddr1_o,
  output fp_pkg::reg_addr_t raddr2_o,
  output fp_pkg::reg_addr_t raddr3_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  fp_pkg::frm_t rm;
  fp_pkg::word_t imm_i_type;
  fp_pkg::word_t imm_s_type;

  fp_pkg::word_t imm;
  logic dec_valid;
  logic dec_ok;
  logic wren;
  logic rden1;
  logic fwren;
  logic frden1;
  logic frden2;
  logic frden3;
  logic fload;
  logic fstore;
  logic fpu;
  logic fpuc;
  logic fpuf;
  fp_pkg::fp_op_t fp_op;
  fp_pkg::lsu_op_t lsu_op;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct5 = instr_i[31:27];
  assign rm = instr_i[14:12];
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  always_comb begin
    imm = '0;
    dec_valid = 1'b1;
    wren = 1'b0;
    rden1 = 1'b0;
    fwren = 1'b0;
    frden1 = 1'b0;
    frden2 = 1'b0;
    frden3 = 1'b0;
    fload = 1'b0;
    fstore = 1'b0;
    fpu = 1'b0;
    fpuc = 1'b0;
    fpuf = 1'b0;
    fp_op = '0;
    lsu_op = '0;
    case (opcode)
      fp_pkg::OPCODE_FLOAD: begin
        imm = imm_i_type;
        rden1 = 1'b1;
        fwren = 1'b1;
        fload = 1'b1;
        lsu_op[fp_pkg::LSU_LW] = 1'b1;
        dec_valid = (funct3 == fp_pkg::FUNCT_LW);
      end
      fp_pkg::OPCODE_FSTORE: begin
        imm = imm_s_type;
        rden1 = 1'b1;
        frden2 = 1'b1;
        fstore = 1'b1;
        lsu_op[fp_pkg::LSU_SW] = 1'b1;
        dec_valid = (funct3 == fp_pkg::FUNCT_SW);
      end
      fp_pkg::OPCODE_FP: begin
        fpu = 1'b1;
        case (funct5)
          fp_pkg::FUNCT_FADD, fp_pkg::FUNCT_FSUB, fp_pkg::FUNCT_FMUL,
          fp_pkg::FUNCT_FDIV, fp_pkg::FUNCT_FSQRT: begin
            fwren = 1'b1;
            frden1 = 1'b1;
            frden2 = (funct5 != fp_pkg::FUNCT_FSQRT); // Square root has one source.
            fpuc = 1'b1;
            fpuf = 1'b1;
            fp_op[fp_pkg::OP_FADD] = (funct5 == fp_pkg::FUNCT_FADD);
            fp_op[fp_pkg::OP_FSUB] = (funct5 == fp_pkg::FUNCT_FSUB);
            fp_op[fp_pkg::OP_FMUL] = (funct5 == fp_pkg::FUNCT_FMUL);
            fp_op[fp_pkg::OP_FDIV] = (funct5 == fp_pkg::FUNCT_FDIV);
            fp_op[fp_pkg::OP_FSQRT] = (funct5 == fp_pkg::FUNCT_FSQRT);
          end
          fp_pkg::FUNCT_FSGNJ: begin
            fwren = 1'b1;
            frden1 = 1'b1;
            frden2 = 1'b1;
            fp_op[fp_pkg::OP_FSGNJ] = 1'b1;
          end
          fp_pkg::FUNCT_FMINMAX: begin
            fwren = 1'b1;
            frden1 = 1'b1;
            frden2 = 1'b1;
            fpuf = 1'b1;
            fp_op[fp_pkg::OP_FMAX] = 1'b1;
          end
          fp_pkg::FUNCT_FCMP: begin
            wren = 1'b1;
            frden1 = 1'b1;
            frden2 = 1'b1;
            fpuf = 1'b1;
            fp_op[fp_pkg::OP_FCMP] = 1'b1;
          end
          fp_pkg::FUNCT_FMV_F2I: begin
            wren = 1'b1;
            frden1 = 1'b1;
            fp_op[fp_pkg::OP_FMV_F2I] = (rm == 3'd0);
            fp_op[fp_pkg::OP_FCLASS] = (rm == 3'd1);
            dec_valid = (rm == 3'd0) || (rm == 3'd1);
          end
          fp_pkg::FUNCT_FMV_I2F: begin
            rden1 = 1'b1;
            fwren = 1'b1;
            fp_op[fp_pkg::OP_FMV_I2F] = 1'b1;
          end
          fp_pkg::FUNCT_FCVT_F2I: begin
            wren = 1'b1;
            frden1 = 1'b1;
            fpuf = 1'b1;
            fp_op[fp_pkg::OP_FCVT_F2I] = 1'b1;
            fp_op[fp_pkg::OP_CVT_LO +: 2] = instr_i[21:20]; // Signed or unsigned word.
          end
          fp_pkg::FUNCT_FCVT_I2F: begin
            rden1 = 1'b1;
            fwren = 1'b1;
            fpuf = 1'b1;
            fp_op[fp_pkg::OP_FCVT_I2F] = 1'b1;
            fp_op[fp_pkg::OP_CVT_LO +: 2] = instr_i[21:20];
          end
          default: dec_valid = 1'b0;
        endcase
      end
      fp_pkg::OPCODE_FMADD, fp_pkg::OPCODE_FMSUB,
      fp_pkg::OPCODE_FNMSUB, fp_pkg::OPCODE_FNMADD: begin
        fwren = 1'b1;
        frden1 = 1'b1;
        frden2 = 1'b1;
        frden3 = 1'b1;
        fpu = 1'b1;
        fpuc = 1'b1;
        fpuf = 1'b1;
        fp_op[fp_pkg::OP_FMADD] = (opcode == fp_pkg::OPCODE_FMADD);
        fp_op[fp_pkg::OP_FMSUB] = (opcode == fp_pkg::OPCODE_FMSUB);
        fp_op[fp_pkg::OP_FNMSUB] = (opcode == fp_pkg::OPCODE_FNMSUB);
        fp_op[fp_pkg::OP_FNMADD] = (opcode == fp_pkg::OPCODE_FNMADD);
      end
      default: dec_valid = 1'b0;
    endcase
  end

  // Rejected or absent instructions leave every enable low.
  assign dec_ok = dec_valid & instr_valid_i;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_o <= 1'b0;
      wren_o <= 1'b0;
      rden1_o <= 1'b0;
      fwren_o <= 1'b0;
      frden1_o <= 1'b0;
      frden2_o <= 1'b0;
      frden3_o <= 1'b0;
      fload_o <= 1'b0;
      fstore_o <= 1'b0;
      fpu_o <= 1'b0;
      fpuc_o <= 1'b0;
      fpuf_o <= 1'b0;
      fp_op_o <= '0;
      lsu_op_o <= '0;
    end else begin
      valid_o <= dec_ok;
      wren_o <= wren & dec_ok;
      rden1_o <= rden1 & dec_ok;
      fwren_o <= fwren & dec_ok;
      frden1_o <= frden1 & dec_ok;
      frden2_o <= frden2 & dec_ok;
      frden3_o <= frden3 & dec_ok;
      fload_o <= fload & dec_ok;
      fstore_o <= fstore & dec_ok;
      fpu_o <= fpu & dec_ok;
      fpuc_o <= fpuc & dec_ok;
      fpuf_o <= fpuf & dec_ok;
      fp_op_o <= dec_ok ? fp_op : '0;
      lsu_op_o <= dec_ok ? lsu_op : '0;
    end
  end

  always_ff @(posedge clock) begin
    imm_o <= imm;
    fmt_o <= instr_i[26:25];
    rm_o <= (rm == fp_pkg::RM_DYN) ? frm_i : rm; // Dynamic mode takes frm from the CSR.
    raddr1_o <= instr_i[19:15];
    raddr2_o <= instr_i[24:20];
    raddr3_o <= instr_i[31:27];
  end

  // Operation bits stay one-hot for each decoded instruction.
  a_op_onehot: assert property (@(posedge clock) disable iff (!reset)
    valid_o |-> $onehot0(fp_op_o[fp_pkg::OP_CVT_LO-1:0]));

endmodule

// ==== rtl/fp_regfile.sv ====
`timescale 1ns/1ps

module fp_regfile (
  input  logic              clock,
  input  logic              reset,
  input  fp_pkg::reg_addr_t raddr1_i,
  input  fp_pkg::reg_addr_t raddr2_i,
  input  fp_pkg::reg_addr_t raddr3_i,
  input  logic              wren_i,
  input  fp_pkg::reg_addr_t waddr_i,
  input  fp_pkg::word_t     wdata_i,
  output fp_pkg::word_t     rdata1_o,
  output fp_pkg::word_t     rdata2_o,
  output fp_pkg::word_t     rdata3_o
);

  fp_pkg::word_t regs [32];

  fp_pkg::reg_addr_t raddr1_q;
  fp_pkg::reg_addr_t raddr2_q;
  fp_pkg::reg_addr_t raddr3_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      raddr1_q <= '0;
      raddr2_q <= '0;
      raddr3_q <= '0;
    end else begin
      raddr1_q <= raddr1_i;
      raddr2_q <= raddr2_i;
      raddr3_q <= raddr3_i;
    end
  end

  always_ff @(posedge clock) begin
    if (wren_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Data lines up with the decode register one cycle after the address.
  assign rdata1_o = regs[raddr1_q];
  assign rdata2_o = regs[raddr2_q];
  assign rdata3_o = regs[raddr3_q];

  a_waddr_known: assert property (@(posedge clock) disable iff (!reset)
    wren_i |-> !$isunknown(waddr_i));

endmodule

// ==== rtl/fp_csr.sv ====
`timescale 1ns/1ps

module fp_csr (
  input  logic              clock,
  input  logic              reset,
  input  logic              csr_rden_i,
  input  fp_pkg::csr_addr_t csr_raddr_i,
  input  logic              csr_wren_i,
  input  fp_pkg::csr_addr_t csr_waddr_i,
  input  fp_pkg::word_t     csr_wdata_i,
  input  logic              exc_valid_i,
  input  fp_pkg::fflags_t   exc_fflags_i,
  output fp_pkg::word_t     csr_rdata_o,
  output logic              csr_ready_o,
  output fp_pkg::frm_t      frm_o
);

  fp_pkg::frm_t frm;
  fp_pkg::fflags_t fflags;

  always_comb begin
    csr_rdata_o = '0;
    csr_ready_o = 1'b0;
    if (csr_rden_i) begin
      case (csr_raddr_i)
        fp_pkg::CSR_FFLAGS: begin
          csr_rdata_o = fp_pkg::word_t'(fflags);
          csr_ready_o = 1'b1;
        end
        fp_pkg::CSR_FRM: begin
          csr_rdata_o = fp_pkg::word_t'(frm);
          csr_ready_o = 1'b1;
        end
        fp_pkg::CSR_FCSR: begin
          csr_rdata_o = fp_pkg::word_t'({frm, fflags}); // frm in [7:5], flags in [4:0].
          csr_ready_o = 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      frm <= '0;
      fflags <= '0;
    end else begin
      if (csr_wren_i) begin
        case (csr_waddr_i)
          fp_pkg::CSR_FFLAGS: fflags <= csr_wdata_i[4:0];
          fp_pkg::CSR_FRM: frm <= csr_wdata_i[2:0];
          fp_pkg::CSR_FCSR: begin
            fflags <= csr_wdata_i[4:0];
            frm <= csr_wdata_i[7:5];
          end
          default: ;
        endcase
      end
      // Exception flags override a same-cycle write.
      if (exc_valid_i) begin
        fflags <= exc_fflags_i;
      end
    end
  end

  assign frm_o = frm;

  // Rounding mode moves only on a CSR write that targets it.
  a_frm_write_only: assert property (@(posedge clock) disable iff (!reset)
    !(csr_wren_i && (csr_waddr_i == fp_pkg::CSR_FRM || csr_waddr_i == fp_pkg::CSR_FCSR))
    |=> $stable(frm));

endmodule

// ==== rtl/fp_forward.sv ====
`timescale 1ns/1ps

module fp_forward (
  input  logic              frden1_i,
  input  logic              frden2_i,
  input  logic              frden3_i,
  input  fp_pkg::reg_addr_t raddr1_i,
  input  fp_pkg::reg_addr_t raddr2_i,
  input  fp_pkg::reg_addr_t raddr3_i,
  input  fp_pkg::word_t     rdata1_i,
  input  fp_pkg::word_t     rdata2_i,
  input  fp_pkg::word_t     rdata3_i,
  input  logic              mem_wren_i,
  input  fp_pkg::reg_addr_t mem_waddr_i,
  input  fp_pkg::word_t     mem_wdata_i,
  input  logic              wb_wren_i,
  input  fp_pkg::reg_addr_t wb_waddr_i,
  input  fp_pkg::word_t     wb_wdata_i,
  output fp_pkg::word_t     data1_o,
  output fp_pkg::word_t     data2_o,
  output fp_pkg::word_t     data3_o
);

  // Youngest producer wins. Memory stage is newer than writeback.
  function automatic fp_pkg::word_t pick(
    input logic              rden,
    input fp_pkg::reg_addr_t raddr,
    input fp_pkg::word_t     rdata
  );
    fp_pkg::word_t res;
    res = '0;
    if (rden) begin
      res = rdata;
      if (wb_wren_i && (wb_waddr_i == raddr)) begin
        res = wb_wdata_i;
      end
      if (mem_wren_i && (mem_waddr_i == raddr)) begin
        res = mem_wdata_i;
      end
    end
    return res;
  endfunction

  always_comb begin
    data1_o = pick(frden1_i, raddr1_i, rdata1_i);
    data2_o = pick(frden2_i, raddr2_i, rdata2_i);
    data3_o = pick(frden3_i, raddr3_i, rdata3_i);
  end

endmodule

// ==== rtl/fp_front.sv ====
`timescale 1ns/1ps

module fp_front (
  input  logic              clock,
  input  logic              reset,
  input  fp_pkg::word_t     instr_i,
  input  logic              instr_valid_i,
  output logic              valid_o,
  output logic              wren_o,
  output logic              rden1_o,
  output logic              fwren_o,
  output logic              frden1_o,
  output logic              frden2_o,
  output logic              frden3_o,
  output logic              fload_o,
  output logic              fstore_o,
  output logic              fpu_o,
  output logic              fpuc_o,
  output logic              fpuf_o,
  output fp_pkg::fp_op_t    fp_op_o,
  output fp_pkg::lsu_op_t   lsu_op_o,
  output fp_pkg::word_t     imm_o,
  output fp_pkg::fmt_t      fmt_o,
  output fp_pkg::frm_t      rm_o,
  output fp_pkg::reg_addr_t raddr1_o,
  output fp_pkg::reg_addr_t raddr2_o,
  output fp_pkg::reg_addr_t raddr3_o,
  input  logic              mem_wren_i,
  input  fp_pkg::reg_addr_t mem_waddr_i,
  input  fp_pkg::word_t     mem_wdata_i,
  input  logic              wb_wren_i,
  input  fp_pkg::reg_addr_t wb_waddr_i,
  input  fp_pkg::word_t     wb_wdata_i,
  input  logic              csr_rden_i,
  input  fp_pkg::csr_addr_t csr_raddr_i,
  input  logic              csr_wren_i,
  input  fp_pkg::csr_addr_t csr_waddr_i,
  input  fp_pkg::word_t     csr_wdata_i,
  input  logic              exc_valid_i,
  input  fp_pkg::fflags_t   exc_fflags_i,
  output fp_pkg::word_t     csr_rdata_o,
  output logic              csr_ready_o,
  output fp_pkg::frm_t      frm_o,
  output fp_pkg::word_t     data1_o,
  output fp_pkg::word_t     data2_o,
  output fp_pkg::word_t     data3_o
);

  fp_pkg::word_t rdata1;
  fp_pkg::word_t rdata2;
  fp_pkg::word_t rdata3;

  fp_decode u_decode (
    .clock(clock), .reset(reset),
    .instr_i(instr_i), .instr_valid_i(instr_valid_i), .frm_i(frm_o),
    .valid_o(valid_o), .wren_o(wren_o), .rden1_o(rden1_o), .fwren_o(fwren_o),
    .frden1_o(frden1_o), .frden2_o(frden2_o), .frden3_o(frden3_o),
    .fload_o(fload_o), .fstore_o(fstore_o),
    .fpu_o(fpu_o), .fpuc_o(fpuc_o), .fpuf_o(fpuf_o),
    .fp_op_o(fp_op_o), .lsu_op_o(lsu_op_o), .imm_o(imm_o), .fmt_o(fmt_o), .rm_o(rm_o),
    .raddr1_o(raddr1_o), .raddr2_o(raddr2_o), .raddr3_o(raddr3_o)
  );

  // Source fields go to the file in the same cycle as decode.
  fp_regfile u_regfile (
    .clock(clock), .reset(reset),
    .raddr1_i(instr_i[19:15]), .raddr2_i(instr_i[24:20]), .raddr3_i(instr_i[31:27]),
    .wren_i(wb_wren_i), .waddr_i(wb_waddr_i), .wdata_i(wb_wdata_i),
    .rdata1_o(rdata1), .rdata2_o(rdata2), .rdata3_o(rdata3)
  );

  fp_forward u_forward (
    .frden1_i(frden1_o), .frden2_i(frden2_o), .frden3_i(frden3_o),
    .raddr1_i(raddr1_o), .raddr2_i(raddr2_o), .raddr3_i(raddr3_o),
    .rdata1_i(rdata1), .rdata2_i(rdata2), .rdata3_i(rdata3),
    .mem_wren_i(mem_wren_i), .mem_waddr_i(mem_waddr_i), .mem_wdata_i(mem_wdata_i),
    .wb_wren_i(wb_wren_i), .wb_waddr_i(wb_waddr_i), .wb_wdata_i(wb_wdata_i),
    .data1_o(data1_o), .data2_o(data2_o), .data3_o(data3_o)
  );

  fp_csr u_csr (
    .clock(clock), .reset(reset),
    .csr_rden_i(csr_rden_i), .csr_raddr_i(csr_raddr_i),
    .csr_wren_i(csr_wren_i), .csr_waddr_i(csr_waddr_i), .csr_wdata_i(csr_wdata_i),
    .exc_valid_i(exc_valid_i), .exc_fflags_i(exc_fflags_i),
    .csr_rdata_o(csr_rdata_o), .csr_ready_o(csr_ready_o), .frm_o(frm_o)
  );

endmodule

// ==== tests/fp_front_tests.svh ====
`ifndef FP_FRONT_TESTS_SVH
`define FP_FRONT_TESTS_SVH

// Stimulus point, 2 ns after the next rising edge.
task automatic next_cycle();
  @(posedge clock);
  #2;
endtask

function automatic fp_pkg::fp_op_t op_bit(input int idx);
  return fp_pkg::fp_op_t'(1) << idx;
endfunction

function automatic fp_pkg::word_t r_type(input logic [4:0] funct5, input fp_pkg::reg_addr_t rs2,
                                         input fp_pkg::reg_addr_t rs1, input fp_pkg::frm_t rm,
                                         input logic [6:0] opcode);
  return {funct5, 2'b00, rs2, rs1, rm, 5'd1, opcode};
endfunction

function automatic fp_pkg::word_t r4_type(input fp_pkg::reg_addr_t rs3,
                                          input fp_pkg::reg_addr_t rs2,
                                          input fp_pkg::reg_addr_t rs1, input logic [6:0] opcode);
  return {rs3, 2'b00, rs2, rs1, 3'b000, 5'd1, opcode};
endfunction

function automatic fp_pkg::word_t load_instr(input logic [11:0] imm, input logic [2:0] funct3);
  return {imm, 5'd2, funct3, 5'd4, fp_pkg::OPCODE_FLOAD};
endfunction

function automatic fp_pkg::word_t store_instr(input logic [11:0] imm);
  return {imm[11:5], 5'd3, 5'd2, fp_pkg::FUNCT_SW, imm[4:0], fp_pkg::OPCODE_FSTORE};
endfunction

// Leaves the caller at the stimulus point of the read cycle.
task automatic send_instr(input fp_pkg::word_t instr);
  instr_i = instr;
  instr_valid_i = 1'b1;
  next_cycle();
  instr_valid_i = 1'b0;
  instr_i = '0;
endtask

task automatic write_reg(input fp_pkg::reg_addr_t addr, input fp_pkg::word_t data);
  wb_wren_i = 1'b1;
  wb_waddr_i = addr;
  wb_wdata_i = data;
  next_cycle();
  wb_wren_i = 1'b0;
  fregs_model[addr] = data;
endtask

task automatic write_csr(input fp_pkg::csr_addr_t addr, input fp_pkg::word_t data);
  csr_wren_i = 1'b1;
  csr_waddr_i = addr;
  csr_wdata_i = data;
  next_cycle();
  csr_wren_i = 1'b0;
endtask

task automatic read_csr(input string name, input fp_pkg::csr_addr_t addr, input logic known,
                        output fp_pkg::word_t data);
  int waited;
  csr_rden_i = 1'b1;
  csr_raddr_i = addr;
  waited = 0;
  @(negedge clock);
  while (!csr_ready_o && waited < 4) begin
    @(negedge clock);
    waited++;
  end
  if (known) begin
    checks++;
    if (!csr_ready_o) begin
      errors++;
      $display("ERROR %s: csr_ready_o never went high for CSR address %h", name, addr);
    end
  end else begin
    check_bit({name, " ready"}, 1'b0, csr_ready_o);
  end
  data = csr_rdata_o;
  next_cycle();
  csr_rden_i = 1'b0;
endtask

// Bits of en, from the top: valid, wren, rden1, fwren, frden1, frden2, frden3,
// fpu, fpuc, fpuf.
task automatic decode_case(input string name, input fp_pkg::word_t instr,
                           input fp_pkg::fp_op_t op, input logic [9:0] en);
  send_instr(instr);
  @(negedge clock);
  check_bit({name, " valid"}, en[9], valid_o);
  check_bit({name, " wren"}, en[8], wren_o);
  check_bit({name, " rden1"}, en[7], rden1_o);
  check_bit({name, " fwren"}, en[6], fwren_o);
  check_bit({name, " frden1"}, en[5], frden1_o);
  check_bit({name, " frden2"}, en[4], frden2_o);
  check_bit({name, " frden3"}, en[3], frden3_o);
  check_bit({name, " fpu"}, en[2], fpu_o);
  check_bit({name, " fpuc"}, en[1], fpuc_o);
  check_bit({name, " fpuf"}, en[0], fpuf_o);
  check_op({name, " op"}, op, fp_op_o);
  next_cycle();
endtask

task automatic mem_case(input string name, input fp_pkg::word_t instr, input logic is_load,
                        input fp_pkg::word_t imm);
  fp_pkg::lsu_op_t lsu_exp;
  lsu_exp = '0;
  lsu_exp[is_load ? fp_pkg::LSU_LW : fp_pkg::LSU_SW] = 1'b1;
  send_instr(instr);
  @(negedge clock);
  check_bit({name, " valid"}, 1'b1, valid_o);
  check_bit({name, " rden1"}, 1'b1, rden1_o);
  check_bit({name, " fwren"}, is_load, fwren_o);
  check_bit({name, " fload"}, is_load, fload_o);
  check_bit({name, " fstore"}, !is_load, fstore_o);
  check_bit({name, " frden2"}, !is_load, frden2_o);
  check_lsu({name, " lsu_op"}, lsu_exp, lsu_op_o);
  check_addr({name, " raddr1"}, 5'd2, raddr1_o);
  check_word({name, " imm"}, imm, imm_o);
  next_cycle();
endtask

task automatic test_reset_state();
  fp_pkg::word_t data;
  @(negedge clock);
  check_bit("reset valid", 1'b0, valid_o);
  check_bit("reset wren", 1'b0, wren_o);
  check_bit("reset fwren", 1'b0, fwren_o);
  check_bit("reset frden1", 1'b0, frden1_o);
  check_bit("reset frden2", 1'b0, frden2_o);
  check_bit("reset frden3", 1'b0, frden3_o);
  check_bit("reset fpu", 1'b0, fpu_o);
  check_op("reset fp_op", '0, fp_op_o);
  check_frm("reset frm", '0, frm_o);
  next_cycle();
  read_csr("reset fflags", fp_pkg::CSR_FFLAGS, 1'b1, data);
  check_word("reset fflags", '0, data);
endtask

task automatic test_decode_table();
  decode_case("fadd", r_type(fp_pkg::FUNCT_FADD, 5'd2, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FADD), 10'b1001110111);
  decode_case("fsub", r_type(fp_pkg::FUNCT_FSUB, 5'd2, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FSUB), 10'b1001110111);
  decode_case("fmul", r_type(fp_pkg::FUNCT_FMUL, 5'd2, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FMUL), 10'b1001110111);
  decode_case("fdiv", r_type(fp_pkg::FUNCT_FDIV, 5'd2, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FDIV), 10'b1001110111);
  decode_case("fsqrt", r_type(fp_pkg::FUNCT_FSQRT, 5'd0, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FSQRT), 10'b1001100111);
  decode_case("fsgnj", r_type(fp_pkg::FUNCT_FSGNJ, 5'd2, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FSGNJ), 10'b1001110100);
  decode_case("fmax", r_type(fp_pkg::FUNCT_FMINMAX, 5'd2, 5'd1, 3'd1, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FMAX), 10'b1001110101);
  decode_case("fcmp", r_type(fp_pkg::FUNCT_FCMP, 5'd2, 5'd1, 3'd2, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FCMP), 10'b1100110101);
  decode_case("fmv.x.w", r_type(fp_pkg::FUNCT_FMV_F2I, 5'd0, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FMV_F2I), 10'b1100100100);
  decode_case("fclass", r_type(fp_pkg::FUNCT_FMV_F2I, 5'd0, 5'd1, 3'd1, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FCLASS), 10'b1100100100);
  decode_case("fmv bad rm", r_type(fp_pkg::FUNCT_FMV_F2I, 5'd0, 5'd1, 3'd2, fp_pkg::OPCODE_FP),
              '0, 10'b0000000000);
  decode_case("fmv.w.x", r_type(fp_pkg::FUNCT_FMV_I2F, 5'd0, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FMV_I2F), 10'b1011000100);
  decode_case("fcvt.wu.s", r_type(fp_pkg::FUNCT_FCVT_F2I, 5'd1, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FCVT_F2I) | op_bit(fp_pkg::OP_CVT_LO), 10'b1100100101);
  decode_case("fcvt.s.wu", r_type(fp_pkg::FUNCT_FCVT_I2F, 5'd1, 5'd1, 3'd0, fp_pkg::OPCODE_FP),
              op_bit(fp_pkg::OP_FCVT_I2F) | op_bit(fp_pkg::OP_CVT_LO), 10'b1011000101);
  decode_case("fmadd", r4_type(5'd3, 5'd2, 5'd1, fp_pkg::OPCODE_FMADD),
              op_bit(fp_pkg::OP_FMADD), 10'b1001111111);
  decode_case("fmsub", r4_type(5'd3, 5'd2, 5'd1, fp_pkg::OPCODE_FMSUB),
              op_bit(fp_pkg::OP_FMSUB), 10'b1001111111);
  decode_case("fnmsub", r4_type(5'd3, 5'd2, 5'd1, fp_pkg::OPCODE_FNMSUB),
              op_bit(fp_pkg::OP_FNMSUB), 10'b1001111111);
  decode_case("fnmadd", r4_type(5'd3, 5'd2, 5'd1, fp_pkg::OPCODE_FNMADD),
              op_bit(fp_pkg::OP_FNMADD), 10'b1001111111);
  mem_case("flw", load_instr(12'hffc, fp_pkg::FUNCT_LW), 1'b1, 32'hffff_fffc);
  mem_case("fsw pos", store_instr(12'h7f0), 1'b0, 32'h0000_07f0);
  mem_case("fsw neg", store_instr(12'h801), 1'b0, 32'hffff_f801);
  decode_case("flw bad funct3", load_instr(12'h004, 3'b011), '0, 10'b0000000000);
  decode_case("bad opcode", {25'h0, 7'b0110011}, '0, 10'b0000000000);
endtask

task automatic test_regfile_read();
  int i;
  for (i = 9; i <= 11; i++) begin
    write_reg(fp_pkg::reg_addr_t'(i), fp_pkg::word_t'($random(seed)));
  end
  send_instr(r4_type(5'd11, 5'd10, 5'd9, fp_pkg::OPCODE_FMADD));
  @(negedge clock);
  check_word("rf data1", fregs_model[9], data1_o);
  check_word("rf data2", fregs_model[10], data2_o);
  check_word("rf data3", fregs_model[11], data3_o);
  check_addr("rf raddr1", 5'd9, raddr1_o);
  check_addr("rf raddr2", 5'd10, raddr2_o);
  check_addr("rf raddr3", 5'd11, raddr3_o);
  check_fmt("rf fmt", 2'b00, fmt_o);
  next_cycle();
  // Square root reads rs1 only.
  send_instr(r_type(fp_pkg::FUNCT_FSQRT, 5'd9, 5'd10, 3'd0, fp_pkg::OPCODE_FP));
  @(negedge clock);
  check_word("rf sqrt data1", fregs_model[10], data1_o);
  check_word("rf sqrt data2", '0, data2_o);
  check_word("rf sqrt data3", '0, data3_o);
  next_cycle();
endtask

task automatic test_forwarding();
  fp_pkg::word_t mem_val;
  fp_pkg::word_t wb_val;
  write_reg(5'd5, fp_pkg::word_t'($random(seed)));
  mem_val = $random(seed);
  wb_val = $random(seed);
  send_instr(r_type(fp_pkg::FUNCT_FADD, 5'd6, 5'd5, 3'd0, fp_pkg::OPCODE_FP));
  mem_wren_i = 1'b1;
  mem_waddr_i = 5'd5;
  mem_wdata_i = mem_val;
  wb_wren_i = 1'b1;
  wb_waddr_i = 5'd5;
  wb_wdata_i = wb_val;
  @(negedge clock);
  check_word("fwd mem over wb", mem_val, data1_o);
  next_cycle();
  fregs_model[5] = wb_val;
  mem_wren_i = 1'b0;
  wb_val = $random(seed);
  send_instr(r_type(fp_pkg::FUNCT_FADD, 5'd6, 5'd5, 3'd0, fp_pkg::OPCODE_FP));
  wb_wdata_i = wb_val;
  @(negedge clock);
  check_word("fwd wb only", wb_val, data1_o);
  next_cycle();
  fregs_model[5] = wb_val;
  send_instr(r_type(fp_pkg::FUNCT_FADD, 5'd6, 5'd5, 3'd0, fp_pkg::OPCODE_FP));
  wb_waddr_i = 5'd7; // Other address, file value expected.
  wb_wdata_i = $random(seed);
  @(negedge clock);
  check_word("fwd no match", fregs_model[5], data1_o);
  next_cycle();
  fregs_model[7] = wb_wdata_i;
  wb_wren_i = 1'b0;
endtask

task automatic test_csr_access();
  fp_pkg::word_t data;
  fp_pkg::fflags_t flags;
  write_csr(fp_pkg::CSR_FRM, 32'd3);
  write_csr(fp_pkg::CSR_FFLAGS, 32'h15);
  frm_model = 3'd3;
  flags = 5'h15;
  read_csr("csr fcsr", fp_pkg::CSR_FCSR, 1'b1, data);
  check_word("csr fcsr", fp_pkg::word_t'({frm_model, flags}), data);
  read_csr("csr frm", fp_pkg::CSR_FRM, 1'b1, data);
  check_word("csr frm", fp_pkg::word_t'(frm_model), data);
  read_csr("csr unknown", 12'h004, 1'b0, data);
  check_word("csr unknown data", '0, data);
  // Exception arrives with an fcsr write.
  csr_wren_i = 1'b1;
  csr_waddr_i = fp_pkg::CSR_FCSR;
  csr_wdata_i = 32'h47;
  exc_valid_i = 1'b1;
  exc_fflags_i = 5'b11000;
  next_cycle();
  csr_wren_i = 1'b0;
  exc_valid_i = 1'b0;
  frm_model = 3'd2;
  flags = 5'b11000;
  read_csr("csr exc", fp_pkg::CSR_FCSR, 1'b1, data);
  check_word("csr exc", fp_pkg::word_t'({frm_model, flags}), data);
  check_frm("csr frm_o", frm_model, frm_o);
endtask

task automatic test_rounding_mode();
  send_instr(r_type(fp_pkg::FUNCT_FADD, 5'd2, 5'd1, fp_pkg::RM_DYN, fp_pkg::OPCODE_FP));
  @(negedge clock);
  check_frm("rm dyn", frm_model, rm_o);
  next_cycle();
  write_csr(fp_pkg::CSR_FRM, 32'd4);
  frm_model = 3'd4;
  send_instr(r_type(fp_pkg::FUNCT_FMUL, 5'd2, 5'd1, fp_pkg::RM_DYN, fp_pkg::OPCODE_FP));
  @(negedge clock);
  check_frm("rm dyn new", frm_model, rm_o);
  next_cycle();
  send_instr(r_type(fp_pkg::FUNCT_FADD, 5'd2, 5'd1, 3'd1, fp_pkg::OPCODE_FP));
  @(negedge clock);
  check_frm("rm static", 3'd1, rm_o);
  next_cycle();
endtask

`endif

// ==== tests/fp_front_tb.sv ====
`timescale 1ns/1ps

module fp_front_tb;

  logic clock;
  logic reset;
  fp_pkg::word_t instr_i;
  logic instr_valid_i;
  logic valid_o, wren_o, rden1_o, fwren_o;
  logic frden1_o, frden2_o, frden3_o;
  logic fload_o, fstore_o, fpu_o, fpuc_o, fpuf_o;
  fp_pkg::fp_op_t fp_op_o;
  fp_pkg::lsu_op_t lsu_op_o;
  fp_pkg::word_t imm_o;
  fp_pkg::fmt_t fmt_o;
  fp_pkg::frm_t rm_o;
  fp_pkg::reg_addr_t raddr1_o, raddr2_o, raddr3_o;
  logic mem_wren_i;
  fp_pkg::reg_addr_t mem_waddr_i;
  fp_pkg::word_t mem_wdata_i;
  logic wb_wren_i;
  fp_pkg::reg_addr_t wb_waddr_i;
  fp_pkg::word_t wb_wdata_i;
  logic csr_rden_i;
  fp_pkg::csr_addr_t csr_raddr_i;
  logic csr_wren_i;
  fp_pkg::csr_addr_t csr_waddr_i;
  fp_pkg::word_t csr_wdata_i;
  logic exc_valid_i;
  fp_pkg::fflags_t exc_fflags_i;
  fp_pkg::word_t csr_rdata_o;
  logic csr_ready_o;
  fp_pkg::frm_t frm_o;
  fp_pkg::word_t data1_o, data2_o, data3_o;

  int errors;
  int checks;
  integer seed;
  fp_pkg::word_t fregs_model [32]; // Values written through writeback.
  fp_pkg::frm_t frm_model;

  always #20 clock = ~clock;

  fp_front UUT (.*);

  task automatic check_word(input string name, input fp_pkg::word_t exp,
                            input fp_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input fp_pkg::fp_op_t exp,
                          input fp_pkg::fp_op_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_frm(input string name, input fp_pkg::frm_t exp,
                           input fp_pkg::frm_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input fp_pkg::reg_addr_t exp,
                            input fp_pkg::reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_lsu(input string name, input fp_pkg::lsu_op_t exp,
                           input fp_pkg::lsu_op_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_fmt(input string name, input fp_pkg::fmt_t exp,
                           input fp_pkg::fmt_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  `include "fp_front_tests.svh"

  initial begin
    clock = 1'b0;
    reset = 1'b0; // Held low for three rising edges.
    errors = 0;
    checks = 0;
    seed = 32'h899d_3d89;
    frm_model = '0;
    // A valid instruction during reset must leave the decode outputs low.
    instr_i = r4_type(5'd3, 5'd2, 5'd1, fp_pkg::OPCODE_FMADD);
    instr_valid_i = 1'b1;
    mem_wren_i = 1'b0;
    mem_waddr_i = '0;
    mem_wdata_i = '0;
    wb_wren_i = 1'b0;
    wb_waddr_i = '0;
    wb_wdata_i = '0;
    csr_rden_i = 1'b0;
    csr_raddr_i = '0;
    csr_wren_i = 1'b0;
    csr_waddr_i = '0;
    csr_wdata_i = '0;
    exc_valid_i = 1'b0;
    exc_fflags_i = '0;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b1;
    instr_valid_i = 1'b0;
    instr_i = '0;

    test_reset_state();
    test_decode_table();
    test_regfile_read();
    test_forwarding();
    test_csr_access();
    test_rounding_mode();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tests
rtl/fp_pkg.sv
rtl/fp_decode.sv
rtl/fp_regfile.sv
rtl/fp_csr.sv
rtl/fp_forward.sv
rtl/fp_front.sv
tests/fp_front_tb.sv
